// File: bench/tb_surface_shader.sv
`include "sdf_defines.svh"

module tb_surface_shader;
    timeunit 1ns;
    timeprecision 1ps;
    import sdf_pkg::*;

    localparam int  TOTAL_LAT = `SDF_VEC_LAT + `SDF_SHADE_LAT;
    localparam real ONE       = 16777216.0;  // 1.0 in 8.24
    localparam real EPS       = 1.0 / 64.0;

    typedef struct {
        int  due;
        real nx, ny, nz;
        real lx, ly, lz;
        int  shade;
        int  rule;  // 0 within tolerance, 1 must be dark, 2 must be full
    } exp_t;

    logic       clk;
    logic       rst;
    logic       valid_in;
    vec3        p;
    vec3        light_pos;
    vec3        surface_normal;
    vec3        light_vector;
    logic [7:0] intensity;
    logic       valid_out;

    integer seed;
    int     cyc = 0;
    int     err_count = 0;
    int     check_count = 0;
    int     beat_count = 0;
    bit     seen_out = 1'b0;
    exp_t   exp_q [$];

    surface_shader i_dut (
        .clk(clk), .rst(rst), .valid_in(valid_in), .p(p), .light_pos(light_pos),
        .surface_normal(surface_normal), .light_vector(light_vector),
        .intensity(intensity), .valid_out(valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic real to_real(input fp v);
        return real'(v) / ONE;
    endfunction

    function automatic fp to_fx(input real r);
        return fp'($rtoi(r * ONE + ((r < 0.0) ? -0.5 : 0.5)));
    endfunction

    function automatic vec3 to_vec(input real x, input real y, input real z);
        vec3 v;
        v.x = to_fx(x);
        v.y = to_fx(y);
        v.z = to_fx(z);
        return v;
    endfunction

    function automatic real abs_r(input real a);
        return (a < 0.0) ? -a : a;
    endfunction

    function automatic real distance(input vec3 a, input vec3 b);
        real dx, dy, dz;
        dx = to_real(b.x) - to_real(a.x);
        dy = to_real(b.y) - to_real(a.y);
        dz = to_real(b.z) - to_real(a.z);
        return $sqrt(dx * dx + dy * dy + dz * dz);
    endfunction

    function automatic real rand_coord(input real span);
        integer r;
        r = $random(seed);
        return span * real'(r % 100000) / 100000.0;
    endfunction

    // Real-valued tetrahedron normal; usable drops on object seams and flat gradients
    function automatic void model_normal(input vec3 pt, output real nx, output real ny,
                                         output real nz, output bit usable);
        real hx [4];
        real hy [4];
        real hz [4];
        real qx, qy, qz, plane, cube, d, len;
        real gx, gy, gz;
        int  floor_hits;
        hx = '{1.0, -1.0, -1.0, 1.0};
        hy = '{-1.0, 1.0, -1.0, 1.0};
        hz = '{-1.0, -1.0, 1.0, 1.0};
        gx = 0.0;
        gy = 0.0;
        gz = 0.0;
        floor_hits = 0;
        usable = 1'b1;
        for (int i = 0; i < 4; i++) begin
            qx = to_real(pt.x) + hx[i] * EPS;
            qy = to_real(pt.y) + hy[i] * EPS;
            qz = to_real(pt.z) + hz[i] * EPS;
            plane = qy + 1.0;  // Floor at y = -1
            cube = abs_r(qx);
            if (abs_r(qy) > cube) cube = abs_r(qy);
            if (abs_r(qz) > cube) cube = abs_r(qz);
            cube = cube - 1.0;
            if (abs_r(plane - cube) < 1.0e-4) usable = 1'b0;
            if (plane <= cube) begin
                floor_hits++;
                d = plane;
            end else begin
                d = cube;
            end
            gx = gx + hx[i] * d;
            gy = gy + hy[i] * d;
            gz = gz + hz[i] * d;
        end
        if (floor_hits != 0 && floor_hits != 4) usable = 1'b0;
        len = $sqrt(gx * gx + gy * gy + gz * gz);
        if (len < 2.0 * EPS) begin
            usable = 1'b0;
            len = 1.0;
        end
        nx = gx / len;
        ny = gy / len;
        nz = gz / len;
    endfunction

    task automatic send_beat(input vec3 pt, input vec3 lt, input int rule);
        exp_t e;
        real  len, dot;
        bit   usable;
        model_normal(pt, e.nx, e.ny, e.nz, usable);
        len = distance(pt, lt);
        e.lx = (to_real(lt.x) - to_real(pt.x)) / len;
        e.ly = (to_real(lt.y) - to_real(pt.y)) / len;
        e.lz = (to_real(lt.z) - to_real(pt.z)) / len;
        dot = e.nx * e.lx + e.ny * e.ly + e.nz * e.lz;
        if (dot <= 0.0)
            e.shade = 0;
        else if (dot >= 1.0)
            e.shade = 255;
        else
            e.shade = $rtoi(255.0 * dot + 0.5);
        e.rule = rule;
        @(negedge clk);
        valid_in  = 1'b1;
        p         = pt;
        light_pos = lt;
        e.due = cyc + TOTAL_LAT;
        exp_q.push_back(e);
        beat_count++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            valid_in = 1'b0;  // Point and light stay on the inputs
        end
    endtask

    task automatic random_pair(output vec3 pt, output vec3 lt);
        real nx, ny, nz;
        bit  usable;
        int  tries;
        tries = 0;
        do begin
            pt = to_vec(rand_coord(2.5), rand_coord(2.5), rand_coord(2.5));
            lt = to_vec(rand_coord(3.0), rand_coord(3.0), rand_coord(3.0));
            model_normal(pt, nx, ny, nz, usable);
            tries++;
        end while ((!usable || distance(pt, lt) < 0.5) && tries < 1000);
        if (!usable || distance(pt, lt) < 0.5) begin
            err_count++;
            $display("No usable random point and light found after %0d tries", tries);
        end
    endtask

    task automatic check_close(input string name, input real expv, input real got,
                               input real tol);
        check_count++;
        assert (abs_r(expv - got) <= tol) else begin
            err_count++;
            $display("ERR t=%0t %s expected %f got %f", $time, name, expv, got);
        end
    endtask

    task automatic check_result(input exp_t e);
        real lx, ly, lz;
        int  got;
        lx = to_real(light_vector.x);
        ly = to_real(light_vector.y);
        lz = to_real(light_vector.z);
        got = int'(intensity);
        check_close("surface_normal.x", e.nx, to_real(surface_normal.x), 0.02);
        check_close("surface_normal.y", e.ny, to_real(surface_normal.y), 0.02);
        check_close("surface_normal.z", e.nz, to_real(surface_normal.z), 0.02);
        check_close("light_vector.x", e.lx, lx, 0.01);
        check_close("light_vector.y", e.ly, ly, 0.01);
        check_close("light_vector.z", e.lz, lz, 0.01);
        check_close("|light_vector|", 1.0, $sqrt(lx * lx + ly * ly + lz * lz), 0.01);
        check_count++;
        case (e.rule)
            1: assert (got == 0) else begin
                err_count++;
                $display("ERR t=%0t intensity expected 0 got %0d", $time, got);
            end
            2: assert (got >= 254) else begin
                err_count++;
                $display("ERR t=%0t intensity expected 254..255 got %0d", $time, got);
            end
            default: assert (got - e.shade <= 2 && e.shade - got <= 2) else begin
                err_count++;
                $display("ERR t=%0t intensity expected %0d got %0d", $time, e.shade, got);
            end
        endcase
    endtask

    // One result per beat, exactly on its due cycle
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (valid_out) seen_out <= 1'b1;
        if (rst) begin
            check_count++;
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                assert (valid_out) else begin
                    err_count++;
                    $display("ERR t=%0t valid_out expected 1 got %0b", $time, valid_out);
                end
                check_result(exp_q.pop_front());
            end else begin
                assert (!valid_out) else begin
                    err_count++;
                    $display("ERR t=%0t valid_out expected 0 got %0b", $time, valid_out);
                end
            end
        end
    end

    assert property (@(posedge clk) !rst |=> !valid_out)
        else begin
            err_count++;
            $display("ERR t=%0t valid_out expected 0 got %0b", $time, $sampled(valid_out));
        end

    // Outputs rest at zero until the first result
    assert property (@(posedge clk) (rst && !seen_out && !valid_out) |-> intensity == 8'd0)
        else begin
            err_count++;
            $display("ERR t=%0t intensity expected 0 got %0d", $time, $sampled(intensity));
        end
    assert property (@(posedge clk) (rst && !seen_out && !valid_out) |->
                     surface_normal == '0)
        else begin
            err_count++;
            $display("ERR t=%0t surface_normal expected 0 got %h", $time,
                     $sampled(surface_normal));
        end
    assert property (@(posedge clk) (rst && !seen_out && !valid_out) |->
                     light_vector == '0)
        else begin
            err_count++;
            $display("ERR t=%0t light_vector expected 0 got %h", $time,
                     $sampled(light_vector));
        end

    task automatic finish_run(input bit timed_out);
        $display("Beats %0d, checks %0d, errors %0d", beat_count, check_count, err_count);
        if (err_count == 0 && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    initial begin
        vec3 pt;
        vec3 lt;
        int  gap;
        int  waited;
        seed      = 32'h4359_ec72;
        rst       = 1'b0;
        valid_in  = 1'b0;
        p         = '0;
        light_pos = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        idle(4);

        // Face centres, floor, then dark and full lighting
        send_beat(to_vec(1.1, 0.0, 0.0), to_vec(2.5, 1.0, 0.5), 0);
        idle(TOTAL_LAT + 2);
        send_beat(to_vec(-1.1, 0.0, 0.0), to_vec(-2.5, 0.5, -1.0), 0);
        idle(TOTAL_LAT + 2);
        send_beat(to_vec(0.0, 1.1, 0.0), to_vec(0.5, 3.0, 0.2), 0);
        idle(TOTAL_LAT + 2);
        send_beat(to_vec(0.0, 0.0, -1.1), to_vec(1.0, 0.5, -3.0), 0);
        idle(TOTAL_LAT + 2);
        send_beat(to_vec(3.0, -0.9, 2.0), to_vec(2.0, 2.0, 1.0), 0);
        idle(TOTAL_LAT + 2);
        send_beat(to_vec(1.1, 0.0, 0.0), to_vec(-3.0, 0.5, 0.0), 1);
        idle(TOTAL_LAT + 2);
        send_beat(to_vec(0.0, 1.1, 0.0), to_vec(0.0, 4.0, 0.0), 2);
        idle(TOTAL_LAT + 2);

        // Back-to-back burst, a new point and light on every beat
        repeat (20) begin
            random_pair(pt, lt);
            send_beat(pt, lt, 0);
        end
        idle(TOTAL_LAT + 2);

        // Gapped burst of random pairs
        repeat (20) begin
            random_pair(pt, lt);
            send_beat(pt, lt, 0);
            gap = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
            idle(gap);
        end

        waited = 0;
        while (exp_q.size() > 0 && waited < 4 * TOTAL_LAT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d results never arrived", exp_q.size());
            finish_run(1'b1);
        end else begin
            idle(TOTAL_LAT + 4);  // Watch for stray valid_out pulses
            finish_run(1'b0);
        end
    end

endmodule

// File: src/inv_sqrt.sv
`include "sdf_defines.svh"

module inv_sqrt (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid_in,
    input  sdf_pkg::fp x,
    output sdf_pkg::fp inv_sqrt,
    output logic       valid_out
);
    import sdf_pkg::*;

    // Mantissa and estimate are unsigned Q2.30 internally
    localparam int SHIFT_BASE = 15 + 3 * (30 - `SDF_FRAC) / 2;
    localparam fp  FP_MAX     = {1'b0, {(`SDF_FP_W-1){1'b1}}};

    logic [31:0] m_q    [0:2];
    logic [31:0] y_q    [0:2];
    logic [3:0]  half_q [0:2];  // Half the normalizing shift
    logic        zero_q [0:2];
    logic        v_q    [0:2];

    logic [31:0] xu;
    logic [4:0]  lz;
    logic [4:0]  sh;
    logic [31:0] m_n;
    logic [7:0]  seed;
    logic        x_zero;
    logic [31:0] y_fin;
    logic [63:0] scaled;

    // One step of y * (3 - m*y*y) / 2
    function automatic logic [31:0] newton_step(input logic [31:0] m, input logic [31:0] y);
        logic [63:0] t1;
        logic [63:0] t2;
        logic [63:0] d;
        logic [63:0] prod;
        t1 = ({32'd0, m} * {32'd0, y}) >> 30;
        t2 = (t1 * {32'd0, y}) >> 30;
        d = (64'd3 << 30) - t2;
        prod = ({32'd0, y} * d) >> 31;
        return prod[31:0];
    endfunction

    // Even leading-zero shift puts the mantissa in [1, 4)
    always_comb begin
        xu = x;
        x_zero = (x <= 0);
        lz = 5'd31;
        for (int i = 0; i < 32; i++) begin
            if (xu[i]) lz = 5'(31 - i);
        end
        sh = {lz[4:1], 1'b0};
        m_n = xu << sh;
        case (m_n[31:28])  // Seed is 1/sqrt of the bucket centre, Q0.8
            4'd4:    seed = 8'd241;
            4'd5:    seed = 8'd218;
            4'd6:    seed = 8'd201;
            4'd7:    seed = 8'd187;
            4'd8:    seed = 8'd176;
            4'd9:    seed = 8'd166;
            4'd10:   seed = 8'd158;
            4'd11:   seed = 8'd151;
            4'd12:   seed = 8'd145;
            4'd13:   seed = 8'd139;
            4'd14:   seed = 8'd134;
            4'd15:   seed = 8'd130;
            default: seed = 8'd255;
        endcase
    end

    // Last Newton step, then scale back to 8.24
    always_comb begin
        y_fin  = newton_step(m_q[2], y_q[2]);
        scaled = ({32'd0, y_fin} << 15) >> (6'(SHIFT_BASE) - 6'(half_q[2]));
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int k = 0; k < 3; k++) begin
                m_q[k]    <= '0;
                y_q[k]    <= '0;
                half_q[k] <= '0;
                zero_q[k] <= 1'b0;
                v_q[k]    <= 1'b0;
            end
            inv_sqrt  <= '0;
            valid_out <= 1'b0;
        end else begin
            v_q[0] <= valid_in;
            if (valid_in) begin
                m_q[0]    <= m_n;
                y_q[0]    <= {2'b00, seed, 22'd0};
                half_q[0] <= sh[4:1];
                zero_q[0] <= x_zero;
            end
            for (int k = 1; k < 3; k++) begin
                v_q[k] <= v_q[k-1];
                if (v_q[k-1]) begin
                    m_q[k]    <= m_q[k-1];
                    y_q[k]    <= newton_step(m_q[k-1], y_q[k-1]);
                    half_q[k] <= half_q[k-1];
                    zero_q[k] <= zero_q[k-1];
                end
            end
            valid_out <= v_q[2];
            if (v_q[2]) begin
                if (zero_q[2] || scaled > 64'(FP_MAX))
                    inv_sqrt <= FP_MAX;  // Saturate tiny and zero inputs
                else
                    inv_sqrt <= fp'(scaled);
            end
        end
    end

endmodule

// File: src/lambert_shade.sv
`include "sdf_defines.svh"

module lambert_shade (
    input  logic         clk,
    input  logic         rst,
    input  logic         valid_in,
    input  sdf_pkg::vec3 surface_normal,
    input  sdf_pkg::vec3 light_vector,
    output logic [7:0]   intensity,
    output logic         valid_out
);
    import sdf_pkg::*;

    localparam int W = `SDF_FP_W + 8;

    fp            dot_r;   // cos of the incidence angle
    logic         valid_s1;
    logic [W-1:0] mag;
    logic [W-1:0] scaled;

    // 255 * dot, rounded to nearest
    always_comb begin
        mag    = {8'd0, dot_r};
        scaled = (mag * W'(255) + (W'(1) << (`SDF_FRAC - 1))) >> `SDF_FRAC;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dot_r     <= '0;
            valid_s1  <= 1'b0;
            intensity <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_s1  <= valid_in;
            valid_out <= valid_s1;
            if (valid_in)
                dot_r <= vec3_dot(surface_normal, light_vector);
            if (valid_s1) begin
                if (dot_r <= 0)
                    intensity <= 8'd0;  // Light behind the surface
                else if (scaled > W'(255))
                    intensity <= 8'd255;
                else
                    intensity <= scaled[7:0];
            end
        end
    end

endmodule

// File: src/scene_query.sv
`include "sdf_defines.svh"

module scene_query (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_in,
    input  sdf_pkg::vec3        pos,
    output sdf_pkg::fp          closest_dist,
    output sdf_pkg::scene_obj_e hit_obj,
    output logic                valid_out
);
    import sdf_pkg::*;

    vec3  abs_r;      // |x|, |y|, |z|
    fp    plane_r;    // Height above the floor
    logic valid_s1;
    fp    cube_max;
    fp    cube_dist;

    // Max-norm box bound
    always_comb begin
        cube_max = abs_r.x;
        if (abs_r.y > cube_max) cube_max = abs_r.y;
        if (abs_r.z > cube_max) cube_max = abs_r.z;
        cube_dist = cube_max - `SDF_CUBE_HALF;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            abs_r    <= '0;
            plane_r  <= '0;
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= valid_in;
            if (valid_in) begin
                abs_r   <= make_vec3(fp_abs(pos.x), fp_abs(pos.y), fp_abs(pos.z));
                plane_r <= pos.y - `SDF_FLOOR_Y;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            closest_dist <= '0;
            hit_obj      <= OBJ_FLOOR;
            valid_out    <= 1'b0;
        end else begin
            valid_out <= valid_s1;
            if (valid_s1) begin
                if (plane_r <= cube_dist) begin  // Ties go to the floor
                    closest_dist <= plane_r;
                    hit_obj      <= OBJ_FLOOR;
                end else begin
                    closest_dist <= cube_dist;
                    hit_obj      <= OBJ_CUBE;
                end
            end
        end
    end

endmodule

// File: src/sdf_defines.svh
`ifndef SDF_DEFINES_SVH
`define SDF_DEFINES_SVH

// Fixed-point format, signed 8.24
`define SDF_FP_W  32
`define SDF_FRAC  24

// Tetrahedron offset, 2^-6
`define SDF_EPS   32'sh0004_0000

// Scene constants
`define SDF_FLOOR_Y    32'shFF00_0000  // -1.0
`define SDF_CUBE_HALF  32'sh0100_0000  // 1.0

// Pipeline latencies in cycles
`define SDF_QUERY_LAT  2
`define SDF_ISQRT_LAT  4
`define SDF_VEC_LAT    9
`define SDF_SHADE_LAT  2

`endif

// File: src/sdf_pkg.sv
`include "sdf_defines.svh"

package sdf_pkg;

    typedef logic signed [`SDF_FP_W-1:0] fp;

    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    // Which scene object gave the smallest distance
    typedef enum logic {
        OBJ_FLOOR = 1'b0,
        OBJ_CUBE  = 1'b1
    } scene_obj_e;

    // Full-width product, rounded to nearest
    function automatic fp fp_mul(input fp a, input fp b);
        logic signed [63:0] wa;
        logic signed [63:0] wb;
        logic signed [63:0] prod;
        wa = a;
        wb = b;
        prod = wa * wb + (64'sd1 <<< (`SDF_FRAC - 1));
        return fp'(prod >>> `SDF_FRAC);
    endfunction

    function automatic vec3 make_vec3(input fp x, input fp y, input fp z);
        vec3 v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    function automatic vec3 vec3_add(input vec3 a, input vec3 b);
        return make_vec3(a.x + b.x, a.y + b.y, a.z + b.z);
    endfunction

    function automatic vec3 vec3_sub(input vec3 a, input vec3 b);
        return make_vec3(a.x - b.x, a.y - b.y, a.z - b.z);
    endfunction

    function automatic vec3 vec3_scale(input vec3 v, input fp s);
        return make_vec3(fp_mul(v.x, s), fp_mul(v.y, s), fp_mul(v.z, s));
    endfunction

    function automatic fp vec3_dot(input vec3 a, input vec3 b);
        return fp_mul(a.x, b.x) + fp_mul(a.y, b.y) + fp_mul(a.z, b.z);
    endfunction

    function automatic fp fp_abs(input fp a);
        return (a < 0) ? -a : a;
    endfunction

endpackage

// File: src/surface_shader.sv
`include "sdf_defines.svh"

module surface_shader (
    input  logic         clk,
    input  logic         rst,
    input  logic         valid_in,
    input  sdf_pkg::vec3 p,
    input  sdf_pkg::vec3 light_pos,
    output sdf_pkg::vec3 surface_normal,
    output sdf_pkg::vec3 light_vector,
    output logic [7:0]   intensity,
    output logic         valid_out
);
    import sdf_pkg::*;

    vec3  vec_normal, vec_light;
    logic vec_valid;
    vec3  normal_dly [0:`SDF_SHADE_LAT-1];  // Matches the shading latency
    vec3  light_dly  [0:`SDF_SHADE_LAT-1];

    surface_vectors i_vectors (.clk(clk), .rst(rst), .valid_in(valid_in), .p(p),
        .light_pos(light_pos), .surface_normal(vec_normal), .light_vector(vec_light),
        .valid_out(vec_valid));

    lambert_shade i_shade (.clk(clk), .rst(rst), .valid_in(vec_valid),
        .surface_normal(vec_normal), .light_vector(vec_light),
        .intensity(intensity), .valid_out(valid_out));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            normal_dly <= '{default: '0};
            light_dly  <= '{default: '0};
        end else begin
            normal_dly[0] <= vec_normal;
            light_dly[0]  <= vec_light;
            for (int i = 1; i < `SDF_SHADE_LAT; i++) begin
                normal_dly[i] <= normal_dly[i-1];
                light_dly[i]  <= light_dly[i-1];
            end
        end
    end

    assign surface_normal = normal_dly[`SDF_SHADE_LAT-1];
    assign light_vector   = light_dly[`SDF_SHADE_LAT-1];

endmodule

// File: src/surface_vectors.sv
`include "sdf_defines.svh"

module surface_vectors #(
    parameter sdf_pkg::fp eps = `SDF_EPS
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         valid_in,
    input  sdf_pkg::vec3 p,
    input  sdf_pkg::vec3 light_pos,
    output sdf_pkg::vec3 surface_normal,
    output sdf_pkg::vec3 light_vector,
    output logic         valid_out
);
    import sdf_pkg::*;

    localparam fp FP_ONE     = fp'(1 <<< `SDF_FRAC);
    localparam fp FP_NEG_ONE = -FP_ONE;
    localparam int P_DLY     = `SDF_QUERY_LAT + 1;

    // Tetrahedron directions
    localparam vec3 H_XYY = {FP_ONE, FP_NEG_ONE, FP_NEG_ONE};
    localparam vec3 H_YXY = {FP_NEG_ONE, FP_ONE, FP_NEG_ONE};
    localparam vec3 H_YYX = {FP_NEG_ONE, FP_NEG_ONE, FP_ONE};
    localparam vec3 H_XXX = {FP_ONE, FP_ONE, FP_ONE};

    vec3  pos_xyy, pos_yxy, pos_yyx, pos_xxx;
    logic valid_s1;
    vec3  p_dly     [0:P_DLY-1];  // Point and light follow the query pipe
    vec3  light_dly [0:P_DLY-1];

    fp          d_xyy, d_yxy, d_yyx, d_xxx;
    scene_obj_e hit_xxx;
    logic       query_valid;

    vec3  grad;
    vec3  normal_r, light_r;
    logic valid_s4;
    fp    normal_mag_sq, light_mag_sq;
    fp    inv_normal_mag, inv_light_mag;
    logic normal_isqrt_valid, light_isqrt_valid;
    vec3  normal_dly [0:`SDF_ISQRT_LAT-1];
    vec3  lvec_dly   [0:`SDF_ISQRT_LAT-1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pos_xyy  <= '0;
            pos_yxy  <= '0;
            pos_yyx  <= '0;
            pos_xxx  <= '0;
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= valid_in;
            if (valid_in) begin
                pos_xyy <= vec3_add(p, vec3_scale(H_XYY, eps));
                pos_yxy <= vec3_add(p, vec3_scale(H_YXY, eps));
                pos_yyx <= vec3_add(p, vec3_scale(H_YYX, eps));
                pos_xxx <= vec3_add(p, vec3_scale(H_XXX, eps));
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            p_dly     <= '{default: '0};
            light_dly <= '{default: '0};
        end else begin
            p_dly[0]     <= p;
            light_dly[0] <= light_pos;
            for (int i = 1; i < P_DLY; i++) begin
                p_dly[i]     <= p_dly[i-1];
                light_dly[i] <= light_dly[i-1];
            end
        end
    end

    scene_query query_xyy (.clk(clk), .rst(rst), .valid_in(valid_s1), .pos(pos_xyy),
        .closest_dist(d_xyy), .hit_obj(), .valid_out());
    scene_query query_yxy (.clk(clk), .rst(rst), .valid_in(valid_s1), .pos(pos_yxy),
        .closest_dist(d_yxy), .hit_obj(), .valid_out());
    scene_query query_yyx (.clk(clk), .rst(rst), .valid_in(valid_s1), .pos(pos_yyx),
        .closest_dist(d_yyx), .hit_obj(), .valid_out());
    scene_query query_xxx (.clk(clk), .rst(rst), .valid_in(valid_s1), .pos(pos_xxx),
        .closest_dist(d_xxx), .hit_obj(hit_xxx), .valid_out(query_valid));

    // Distance-weighted sum of the four directions
    always_comb begin
        grad = vec3_add(vec3_add(vec3_scale(H_XYY, d_xyy), vec3_scale(H_YXY, d_yxy)),
                        vec3_add(vec3_scale(H_YYX, d_yyx), vec3_scale(H_XXX, d_xxx)));
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            normal_r <= '0;
            light_r  <= '0;
            valid_s4 <= 1'b0;
        end else begin
            valid_s4 <= query_valid;
            if (query_valid) begin
                if (hit_xxx == OBJ_FLOOR)
                    normal_r <= make_vec3('0, fp'(eps <<< 2), '0);  // Exact plane gradient
                else
                    normal_r <= grad;
                light_r <= vec3_sub(light_dly[P_DLY-1], p_dly[P_DLY-1]);
            end
        end
    end

    always_comb begin
        normal_mag_sq = vec3_dot(normal_r, normal_r);
        light_mag_sq  = vec3_dot(light_r, light_r);
    end

    inv_sqrt normal_isqrt (.clk(clk), .rst(rst), .valid_in(valid_s4), .x(normal_mag_sq),
        .inv_sqrt(inv_normal_mag), .valid_out(normal_isqrt_valid));
    inv_sqrt light_isqrt (.clk(clk), .rst(rst), .valid_in(valid_s4), .x(light_mag_sq),
        .inv_sqrt(inv_light_mag), .valid_out(light_isqrt_valid));

    // Hold the raw vectors until their magnitudes come back
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            normal_dly <= '{default: '0};
            lvec_dly   <= '{default: '0};
        end else begin
            normal_dly[0] <= normal_r;
            lvec_dly[0]   <= light_r;
            for (int i = 1; i < `SDF_ISQRT_LAT; i++) begin
                normal_dly[i] <= normal_dly[i-1];
                lvec_dly[i]   <= lvec_dly[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            surface_normal <= '0;
            light_vector   <= '0;
            valid_out      <= 1'b0;
        end else begin
            valid_out <= normal_isqrt_valid && light_isqrt_valid;
            if (normal_isqrt_valid && light_isqrt_valid) begin
                surface_normal <= vec3_scale(normal_dly[`SDF_ISQRT_LAT-1], inv_normal_mag);
                light_vector   <= vec3_scale(lvec_dly[`SDF_ISQRT_LAT-1], inv_light_mag);
            end
        end
    end

endmodule

// File: verilog.f
+incdir+src
src/sdf_pkg.sv
src/scene_query.sv
src/inv_sqrt.sv
src/surface_vectors.sv
src/lambert_shade.sv
src/surface_shader.sv
bench/tb_surface_shader.sv
